/* Bender.yml */
package:
  name: snake_engine

sources:
  - include_dirs:
      - .
    files:
      - snakePkg.sv
      - headingControl.sv
      - snakeBody.sv
      - collisionCheck.sv
      - blockPlotter.sv
      - gameController.sv
      - snakeTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - snakeTop_props.sv
      - tb_snakeTop.sv

/* all.f */
+incdir+.
snakePkg.sv
headingControl.sv
snakeBody.sv
collisionCheck.sv
blockPlotter.sv
gameController.sv
snakeTop.sv
snakeTop_props.sv
tb_snakeTop.sv

/* blockPlotter.sv */
// --------------------------------------------------------------------------
// Cell block scanner
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "snake_defines.svh"

module blockPlotter
(
    input  logic              Clock,
    input  logic              reset,
    input  logic              blockStart,
    input  snakePkg::cellX_t  blockCellX,
    input  snakePkg::cellY_t  blockCellY,
    input  snakePkg::colour_t blockColour,
    output snakePkg::pixelX_t pixelX,
    output snakePkg::pixelY_t pixelY,
    output snakePkg::colour_t pixelColour,
    output logic              plot,
    output logic              blockDone
);

    import snakePkg::*;

    cellX_t     cellXReg;
    cellY_t     cellYReg;
    colour_t    colourReg;
    logic       active;
    logic [3:0] xOff;
    logic [3:0] yOff;
    logic       lastX;
    logic       lastY;

    // block parameters captured at start
    always_ff @(posedge Clock)
    begin
        if (blockStart)
        begin
            cellXReg  <= blockCellX;
            cellYReg  <= blockCellY;
            colourReg <= blockColour;
        end
    end

    assign lastX = (xOff == 4'(`CellSize - 1));
    assign lastY = (yOff == 4'(`CellSize - 1));

    // raster scan, x offset fastest
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            active <= 1'b0;
            xOff   <= '0;
            yOff   <= '0;
        end
        else if (blockStart)
        begin
            active <= 1'b1;
            xOff   <= '0;
            yOff   <= '0;
        end
        else if (active)
        begin
            if (lastX)
            begin
                xOff <= '0;
                // bottom right corner ends the block
                if (lastY)
                    active <= 1'b0;
                else
                    yOff <= yOff + 1'b1;
            end
            else
            begin
                xOff <= xOff + 1'b1;
            end
        end
    end

    // cell origin plus scan offset
    assign pixelX = pixelX_t'(cellXReg) * pixelX_t'(`CellSize) + pixelX_t'(xOff);
    assign pixelY = pixelY_t'(cellYReg) * pixelY_t'(`CellSize) + pixelY_t'(yOff);
    assign pixelColour = colourReg;
    assign plot = active;
    assign blockDone = active & lastX & lastY;

endmodule

/* collisionCheck.sv */
// --------------------------------------------------------------------------
// Self collision test
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "snake_defines.svh"

module collisionCheck
(
    input  snakePkg::cellX_t                    nextHeadX,
    input  snakePkg::cellY_t                    nextHeadY,
    input  snakePkg::cellX_t [`SnakeLength-1:0] bodyX,
    input  snakePkg::cellY_t [`SnakeLength-1:0] bodyY,
    output logic                                hit
);

    // compare against segments 1 up to the one before the tail
    // the tail cell frees up on the same step
    // segment 0 is skipped, so a standing snake never hits itself
    always_comb
    begin
        hit = 1'b0;
        for (int i = 1; i <= `SnakeLength - 2; i++)
        begin
            if ((nextHeadX == bodyX[i]) && (nextHeadY == bodyY[i]))
            begin
                hit = 1'b1;
            end
        end
    end

endmodule

/* gameController.sv */
// --------------------------------------------------------------------------
// Frame sequencer
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "snake_defines.svh"

module gameController
#(
    parameter int StepBits = `DefaultStepBits
)
(
    input  logic                Clock,
    input  logic                reset,
    input  logic                go,
    input  logic                hit,
    input  logic                blockDone,
    input  snakePkg::colour_t   bodyColour,
    input  snakePkg::cellX_t    segX,
    input  snakePkg::cellY_t    segY,
    output snakePkg::segIndex_t segIndex,
    output logic                blockStart,
    output logic                stepBody,
    output logic                gameOver,
    output snakePkg::cellX_t    blockCellX,
    output snakePkg::cellY_t    blockCellY,
    output snakePkg::colour_t   blockColour
);

    import snakePkg::*;

    gameState_t          state;
    gameState_t          stateNext;
    logic                blockBusy;
    logic                drawing;
    logic                lastSeg;
    logic [StepBits-1:0] paceCount;
    logic                tick;

    // free running pacing counter
    always_ff @(posedge Clock)
    begin
        if (reset)
            paceCount <= '0;
        else
            paceCount <= paceCount + 1'b1;
    end

    assign tick = (paceCount == '0);

    // block plotting states
    assign drawing = (state == stDrawApple) || (state == stDrawBody) || (state == stEraseBody);
    assign lastSeg = (segIndex == segIndex_t'(`SnakeLength - 1));

    // one start pulse per block, busy until the plotter finishes
    assign blockStart = drawing & ~blockBusy;

    always_ff @(posedge Clock)
    begin
        if (reset)
            blockBusy <= 1'b0;
        else if (blockStart)
            blockBusy <= 1'b1;
        else if (blockDone)
            blockBusy <= 1'b0;
    end

    always_comb
    begin
        stateNext = state;
        case (state)
            stIdle:      if (go) stateNext = stDrawApple;
            stDrawApple: if (blockDone) stateNext = stDrawBody;
            stDrawBody:  if (blockDone && lastSeg) stateNext = stWaitTick;
            stWaitTick:  if (tick) stateNext = stEraseBody;
            stEraseBody: if (blockDone && lastSeg) stateNext = stCheckHit;
            stCheckHit:  stateNext = hit ? stGameOver : stMove;
            stMove:      stateNext = stDrawApple;
            // game over only leaves on reset
            default:     stateNext = stGameOver;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
            state <= stIdle;
        else
            state <= stateNext;
    end

    // segment walk for the draw and erase passes
    always_ff @(posedge Clock)
    begin
        if (reset)
            segIndex <= '0;
        else if (blockDone && ((state == stDrawBody) || (state == stEraseBody)))
            segIndex <= lastSeg ? '0 : segIndex + 1'b1;
    end

    // apple comes from constants, body cells from the segment store
    assign blockCellX = (state == stDrawApple) ? cellX_t'(`AppleX) : segX;
    assign blockCellY = (state == stDrawApple) ? cellY_t'(`AppleY) : segY;
    assign blockColour = (state == stDrawApple) ? colour_t'(`AppleColour) :
                         (state == stEraseBody) ? colour_t'(`EraseColour) : bodyColour;

    assign stepBody = (state == stMove);
    assign gameOver = (state == stGameOver);

endmodule

/* headingControl.sv */
// --------------------------------------------------------------------------
// Heading register
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module headingControl
(
    input  logic              Clock,
    input  logic              reset,
    input  logic              keyRight,
    input  logic              keyDown,
    input  logic              keyUp,
    input  logic              keyLeft,
    output snakePkg::heading_t heading
);

    import snakePkg::*;

    // last key wins and holds until the next one
    // right beats down beats up beats left on a tie
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            heading <= headNone;
        end
        else if (keyRight)
        begin
            heading <= headRight;
        end
        else if (keyDown)
        begin
            heading <= headDown;
        end
        else if (keyUp)
        begin
            heading <= headUp;
        end
        else if (keyLeft)
        begin
            heading <= headLeft;
        end
    end

endmodule

/* snakeBody.sv */
// --------------------------------------------------------------------------
// Snake segment store
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "snake_defines.svh"

module snakeBody
(
    input  logic                                  Clock,
    input  logic                                  reset,
    input  logic                                  stepBody,
    input  snakePkg::heading_t                    heading,
    input  snakePkg::segIndex_t                   segIndex,
    output snakePkg::cellX_t                      segX,
    output snakePkg::cellY_t                      segY,
    output snakePkg::cellX_t                      nextHeadX,
    output snakePkg::cellY_t                      nextHeadY,
    output snakePkg::cellX_t [`SnakeLength-1:0]   bodyX,
    output snakePkg::cellY_t [`SnakeLength-1:0]   bodyY
);

    import snakePkg::*;

    // next head cell, one step in the heading
    // wraps to the opposite edge of the grid
    always_comb
    begin
        nextHeadX = bodyX[0];
        nextHeadY = bodyY[0];
        case (heading)
            headRight:
            begin
                nextHeadX = (bodyX[0] == cellX_t'(`GridWidth - 1)) ? '0 : bodyX[0] + 1'b1;
            end
            headLeft:
            begin
                nextHeadX = (bodyX[0] == '0) ? cellX_t'(`GridWidth - 1) : bodyX[0] - 1'b1;
            end
            headDown:
            begin
                nextHeadY = (bodyY[0] == cellY_t'(`GridHeight - 1)) ? '0 : bodyY[0] + 1'b1;
            end
            headUp:
            begin
                nextHeadY = (bodyY[0] == '0) ? cellY_t'(`GridHeight - 1) : bodyY[0] - 1'b1;
            end
            // no heading yet, the head stays put
            default:
            begin
            end
        endcase
    end

    // segment shift register, index 0 is the head
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            // vertical column with the head on top
            for (int i = 0; i < `SnakeLength; i++)
            begin
                bodyX[i] <= cellX_t'(`StartHeadX);
                bodyY[i] <= cellY_t'(`StartHeadY + i);
            end
        end
        // without a heading the snake keeps its cells
        else if (stepBody && (heading != headNone))
        begin
            // every segment takes its neighbour's cell toward the head
            bodyX <= {bodyX[`SnakeLength-2:0], nextHeadX};
            bodyY <= {bodyY[`SnakeLength-2:0], nextHeadY};
        end
    end

    // read port for the draw and erase passes
    assign segX = bodyX[segIndex];
    assign segY = bodyY[segIndex];

endmodule

/* snakePkg.sv */
// --------------------------------------------------------------------------
// Snake engine types
// --------------------------------------------------------------------------
package snakePkg;

    // framebuffer coordinates
    typedef logic [7:0] pixelX_t;
    typedef logic [6:0] pixelY_t;

    // grid coordinates
    typedef logic [3:0] cellX_t;
    typedef logic [3:0] cellY_t;

    // one bit per rgb channel
    typedef logic [2:0] colour_t;

    // segment number, head is 0
    typedef logic [2:0] segIndex_t;

    // direction of travel, none until a key arrives
    typedef enum logic [2:0]
    {
        headNone,
        headRight,
        headDown,
        headUp,
        headLeft
    } heading_t;

    // frame sequencer states
    typedef enum logic [3:0]
    {
        stIdle,
        stDrawApple,
        stDrawBody,
        stWaitTick,
        stEraseBody,
        stCheckHit,
        stMove,
        stGameOver
    } gameState_t;

endpackage

/* snakeTop.sv */
// --------------------------------------------------------------------------
// Snake engine top level
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "snake_defines.svh"

module snakeTop
#(
    parameter int StepBits = `DefaultStepBits
)
(
    input  logic              Clock,
    input  logic              reset,
    input  logic              go,
    input  logic              keyRight,
    input  logic              keyDown,
    input  logic              keyUp,
    input  logic              keyLeft,
    input  snakePkg::colour_t bodyColour,
    output snakePkg::pixelX_t pixelX,
    output snakePkg::pixelY_t pixelY,
    output snakePkg::colour_t pixelColour,
    output logic              plot,
    output logic              gameOver
);

    import snakePkg::*;

    heading_t                    heading;
    segIndex_t                   segIndex;
    cellX_t                      segX;
    cellY_t                      segY;
    cellX_t                      nextHeadX;
    cellY_t                      nextHeadY;
    cellX_t [`SnakeLength-1:0]   bodyX;
    cellY_t [`SnakeLength-1:0]   bodyY;
    logic                        hit;
    logic                        stepBody;
    logic                        blockStart;
    logic                        blockDone;
    cellX_t                      blockCellX;
    cellY_t                      blockCellY;
    colour_t                     blockColour;

    headingControl headingControl_i
    (
        .Clock    (Clock),
        .reset    (reset),
        .keyRight (keyRight),
        .keyDown  (keyDown),
        .keyUp    (keyUp),
        .keyLeft  (keyLeft),
        .heading  (heading)
    );

    snakeBody snakeBody_i
    (
        .Clock     (Clock),
        .reset     (reset),
        .stepBody  (stepBody),
        .heading   (heading),
        .segIndex  (segIndex),
        .segX      (segX),
        .segY      (segY),
        .nextHeadX (nextHeadX),
        .nextHeadY (nextHeadY),
        .bodyX     (bodyX),
        .bodyY     (bodyY)
    );

    collisionCheck collisionCheck_i
    (
        .nextHeadX (nextHeadX),
        .nextHeadY (nextHeadY),
        .bodyX     (bodyX),
        .bodyY     (bodyY),
        .hit       (hit)
    );

    // sequencer feeds the plotter one block at a time
    gameController #(.StepBits(StepBits)) gameController_i
    (
        .Clock       (Clock),
        .reset       (reset),
        .go          (go),
        .hit         (hit),
        .blockDone   (blockDone),
        .bodyColour  (bodyColour),
        .segX        (segX),
        .segY        (segY),
        .segIndex    (segIndex),
        .blockStart  (blockStart),
        .stepBody    (stepBody),
        .gameOver    (gameOver),
        .blockCellX  (blockCellX),
        .blockCellY  (blockCellY),
        .blockColour (blockColour)
    );

    blockPlotter blockPlotter_i
    (
        .Clock       (Clock),
        .reset       (reset),
        .blockStart  (blockStart),
        .blockCellX  (blockCellX),
        .blockCellY  (blockCellY),
        .blockColour (blockColour),
        .pixelX      (pixelX),
        .pixelY      (pixelY),
        .pixelColour (pixelColour),
        .plot        (plot),
        .blockDone   (blockDone)
    );

endmodule

/* snakeTop_props.sv */
// --------------------------------------------------------------------------
// Snake top level properties
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "snake_defines.svh"

module snakeTop_props
(
    input logic              Clock,
    input logic              reset,
    input logic              plot,
    input logic              gameOver,
    input snakePkg::pixelX_t pixelX,
    input snakePkg::pixelY_t pixelY
);

    // failures so far, read by the testbench
    int failCount = 0;

    // nothing drawn once the game has ended
    plotAfterEnd: assert property (@(posedge Clock) disable iff (reset) !(plot && gameOver))
    else
    begin
        $error("plot high during game over");
        failCount++;
    end

    // game over holds until reset
    endHolds: assert property (@(posedge Clock) disable iff (reset) gameOver |=> gameOver)
    else
    begin
        $error("gameOver fell without reset");
        failCount++;
    end

    // pixels stay on screen
    onScreen: assert property (@(posedge Clock) disable iff (reset)
        plot |-> (pixelX < `ScreenWidth) && (pixelY < `ScreenHeight))
    else
    begin
        $error("pixel outside the framebuffer");
        failCount++;
    end

endmodule

bind snakeTop snakeTop_props props_i
(
    .Clock    (Clock),
    .reset    (reset),
    .plot     (plot),
    .gameOver (gameOver),
    .pixelX   (pixelX),
    .pixelY   (pixelY)
);

/* snake_defines.svh */
// --------------------------------------------------------------------------
// Snake engine constants
// --------------------------------------------------------------------------
`ifndef SNAKE_DEFINES_SVH
`define SNAKE_DEFINES_SVH

// framebuffer size in pixels
`define ScreenWidth 160
`define ScreenHeight 120

// one grid cell is a square block of pixels
`define CellSize 10
`define GridWidth 16
`define GridHeight 12

// snake geometry, head first, body hangs below the head
`define SnakeLength 6
`define StartHeadX 8
`define StartHeadY 6

// apple position and palette
`define AppleX 3
`define AppleY 3
`define AppleColour 3'b100
`define EraseColour 3'b000

// pacing counter width for the board
`define DefaultStepBits 20

`endif

/* tb_snakeTop.sv */
// --------------------------------------------------------------------------
// Snake engine testbench
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "snake_defines.svh"

module tb_snakeTop;

    import snakePkg::*;

    localparam int StepBits = 6;
    localparam int BlocksPerFrame = 2 * `SnakeLength + 1;
    // 13 blocks with a gap each, worst case tick wait, state overhead
    localparam int FrameCycles = BlocksPerFrame * (`CellSize * `CellSize + 1)
                                 + (1 << StepBits) + 8;
    // 14 frames steering right, 3 for the straight collision, 8 for the turns
    localparam int TotalFrames = 14 + 3 + 8;
    localparam int TimeoutCycles = 4 * (TotalFrames * FrameCycles + 1000);

    logic Clock;
    logic reset;
    logic go;
    logic keyRight;
    logic keyDown;
    logic keyUp;
    logic keyLeft;
    colour_t bodyColour;
    pixelX_t pixelX;
    pixelY_t pixelY;
    colour_t pixelColour;
    logic plot;
    logic gameOver;

    // reference model state
    cellX_t modelX [`SnakeLength];
    cellY_t modelY [`SnakeLength];
    heading_t modelHeading;
    heading_t keyPlan [$];

    // expected blocks in plot order
    cellX_t expX [$];
    cellY_t expY [$];
    colour_t expC [$];

    int blocksChecked = 0;
    int cycleCount = 0;
    logic [31:0] lcgState;
    logic gameEnded;

    // compare process state
    int runLen = 0;
    cellX_t curX;
    cellY_t curY;
    colour_t curC;
    pixelX_t wantX;
    pixelY_t wantY;

    snakeTop #(.StepBits(StepBits)) dut_i
    (
        .Clock       (Clock),
        .reset       (reset),
        .go          (go),
        .keyRight    (keyRight),
        .keyDown     (keyDown),
        .keyUp       (keyUp),
        .keyLeft     (keyLeft),
        .bodyColour  (bodyColour),
        .pixelX      (pixelX),
        .pixelY      (pixelY),
        .pixelColour (pixelColour),
        .plot        (plot),
        .gameOver    (gameOver)
    );

    initial
    begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    task automatic abortRun();
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // reference step: move the head one cell, wrap, test segments 1 to 4
    // returns 1 on a collision and leaves the body as it was
    // a snake without heading stays in place
    function automatic logic advanceModel();
        int nx;
        int ny;
        logic hitFlag;
        nx = int'(modelX[0]);
        ny = int'(modelY[0]);
        hitFlag = 1'b0;
        case (modelHeading)
            headRight: nx = (nx + 1) % `GridWidth;
            headLeft:  nx = (nx + `GridWidth - 1) % `GridWidth;
            headDown:  ny = (ny + 1) % `GridHeight;
            headUp:    ny = (ny + `GridHeight - 1) % `GridHeight;
            default:   nx = nx;
        endcase
        for (int i = 1; i <= `SnakeLength - 2; i++)
        begin
            if ((nx == int'(modelX[i])) && (ny == int'(modelY[i])))
                hitFlag = 1'b1;
        end
        if (!hitFlag && (modelHeading != headNone))
        begin
            for (int i = `SnakeLength - 1; i > 0; i--)
            begin
                modelX[i] = modelX[i-1];
                modelY[i] = modelY[i-1];
            end
            modelX[0] = cellX_t'(nx);
            modelY[0] = cellY_t'(ny);
        end
        return hitFlag;
    endfunction

    // apple, body in colour, body in black
    task automatic queueFrame();
        expX.push_back(cellX_t'(`AppleX));
        expY.push_back(cellY_t'(`AppleY));
        expC.push_back(colour_t'(`AppleColour));
        for (int pass = 0; pass < 2; pass++)
        begin
            for (int i = 0; i < `SnakeLength; i++)
            begin
                expX.push_back(modelX[i]);
                expY.push_back(modelY[i]);
                expC.push_back((pass == 0) ? bodyColour : colour_t'(`EraseColour));
            end
        end
    endtask

    task automatic applyReset();
        @(posedge Clock);
        reset <= 1'b1;
        go <= 1'b0;
        repeat (2) @(posedge Clock);
        reset <= 1'b0;
        bodyColour <= colour_t'((nextRandom() >> 16) % 7 + 1);
        expX.delete();
        expY.delete();
        expC.delete();
        modelHeading = headNone;
        for (int i = 0; i < `SnakeLength; i++)
        begin
            modelX[i] = cellX_t'(`StartHeadX);
            modelY[i] = cellY_t'(`StartHeadY + i);
        end
    endtask

    task automatic pressKey(input heading_t key);
        @(posedge Clock);
        keyRight <= (key == headRight);
        keyDown <= (key == headDown);
        keyUp <= (key == headUp);
        keyLeft <= (key == headLeft);
        @(posedge Clock);
        keyRight <= 1'b0;
        keyDown <= 1'b0;
        keyUp <= 1'b0;
        keyLeft <= 1'b0;
    endtask

    task automatic expectGameOver();
        int n;
        n = 0;
        while (!gameOver && n < 10)
        begin
            @(posedge Clock);
            n++;
        end
        assert (gameOver) else
        begin
            $display("gameOver did not rise after the colliding frame");
            abortRun();
        end
        // the engine must stay silent from here on
        repeat (200)
        begin
            @(posedge Clock);
            assert (!plot && gameOver) else
            begin
                $display("engine plotted or left game over after the collision");
                abortRun();
            end
        end
    endtask

    // one frame per loop, keyPlan gives the key for each frame
    task automatic runGame(input int numFrames, output logic ended);
        int base;
        ended = 1'b0;
        @(posedge Clock);
        go <= 1'b1;
        for (int f = 0; f < numFrames && !ended; f++)
        begin
            base = blocksChecked;
            queueFrame();
            // wait for the apple or an early game over
            while (!plot && !gameOver) @(posedge Clock);
            assert (!gameOver) else
            begin
                $display("FAILED gameOver: got %h expected %h", gameOver, 1'b0);
                abortRun();
            end
            while (blocksChecked < base + 1) @(posedge Clock);
            // key lands during the body pass, well before the move
            if (f < keyPlan.size() && keyPlan[f] != headNone)
            begin
                pressKey(keyPlan[f]);
                modelHeading = keyPlan[f];
            end
            while (blocksChecked < base + BlocksPerFrame) @(posedge Clock);
            ended = advanceModel();
        end
        if (ended)
            expectGameOver();
    endtask

    // block checker, one run of plot high cycles per block
    always @(posedge Clock)
    begin
        if (reset)
        begin
            runLen = 0;
        end
        else if (plot)
        begin
            if (runLen == 0)
            begin
                assert (expX.size() != 0) else
                begin
                    $display("plot rose while no block was expected");
                    abortRun();
                end
                curX = expX.pop_front();
                curY = expY.pop_front();
                curC = expC.pop_front();
            end
            assert (runLen < `CellSize * `CellSize) else
            begin
                $display("plot stayed high past the end of a block");
                abortRun();
            end
            // scan order is x offset fastest
            wantX = pixelX_t'(int'(curX) * `CellSize + runLen % `CellSize);
            wantY = pixelY_t'(int'(curY) * `CellSize + runLen / `CellSize);
            assert (pixelX == wantX) else
            begin
                $display("FAILED pixelX: got %h expected %h", pixelX, wantX);
                abortRun();
            end
            assert (pixelY == wantY) else
            begin
                $display("FAILED pixelY: got %h expected %h", pixelY, wantY);
                abortRun();
            end
            assert (pixelColour == curC) else
            begin
                $display("FAILED pixelColour: got %h expected %h", pixelColour, curC);
                abortRun();
            end
            runLen++;
        end
        else if (runLen != 0)
        begin
            assert (runLen == `CellSize * `CellSize) else
            begin
                $display("FAILED plot run length: got %h expected %h",
                         runLen, `CellSize * `CellSize);
                abortRun();
            end
            runLen = 0;
            blocksChecked++;
        end
    end

    // run limit, and failures of the bound properties
    always @(posedge Clock)
    begin
        cycleCount++;
        assert (cycleCount < TimeoutCycles) else
        begin
            $display("run did not finish within %0d cycles", TimeoutCycles);
            abortRun();
        end
        assert (dut_i.props_i.failCount == 0) else
        begin
            $display("a bound property on the top level outputs failed");
            abortRun();
        end
    end

    initial
    begin
        reset = 1'b1;
        go = 1'b0;
        keyRight = 1'b0;
        keyDown = 1'b0;
        keyUp = 1'b0;
        keyLeft = 1'b0;
        bodyColour = '0;
        lcgState = 32'd75;
        applyReset();

        // idle with go low
        repeat (40)
        begin
            @(posedge Clock);
            assert (!plot && !gameOver) else
            begin
                $display("engine became active while go was low");
                abortRun();
            end
        end

        // standing snake, then right across column 15 and back in at 0
        keyPlan = '{headNone, headNone, headRight};
        runGame(14, gameEnded);
        assert (!gameEnded) else
        begin
            $display("straight run to the right ended in a collision");
            abortRun();
        end

        // down runs the head into segment 1
        applyReset();
        keyPlan = '{headDown};
        runGame(3, gameEnded);
        assert (gameEnded) else
        begin
            $display("turning down into the body did not end the game");
            abortRun();
        end

        // right, down, left, up loop back into the body
        applyReset();
        keyPlan = '{headRight, headNone, headDown, headLeft, headUp};
        runGame(8, gameEnded);
        assert (gameEnded) else
        begin
            $display("turning loop did not end the game");
            abortRun();
        end

        if (dut_i.props_i.failCount == 0)
        begin
            $display("Simulation passed");
            $finish;
        end
        else
        begin
            $display("a bound property failed at the end of the run");
            abortRun();
        end
    end

endmodule
